// ==== common/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

  typedef logic [22:0] flash_addr_t;  // Word address
  typedef logic [31:0] flash_word_t;

  typedef struct packed {
    logic        read;
    flash_addr_t addr;
  } flash_req_t;

  typedef struct packed {
    logic        readdatavalid;
    flash_word_t data;
  } flash_rsp_t;

  typedef enum logic [2:0] {
    PH_AA,
    PH_EE,
    PH_OO,
    PH_SS,
    PH_MM,
    PH_NN,
    PH_KK,
    PH_SIL
  } phoneme_t;

  // Inclusive word range of one phoneme
  typedef struct packed {
    flash_addr_t start_addr;
    flash_addr_t end_addr;
    logic        silent;
  } phoneme_range_t;

  localparam int PHONEME_WORDS = 4;

  // Code n starts at word n*8
  function automatic flash_addr_t phoneme_base(input phoneme_t code);
    return flash_addr_t'(code) << 3;
  endfunction

endpackage

`default_nettype wire

// ==== common/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

  typedef logic signed [7:0] sample_t;
  typedef logic [15:0]       rate_div_t;   // CLK_50M cycles per sample
  typedef logic [7:0]        led_bar_t;

  // ============================================================
  // Sample rate defaults
  // ============================================================

  localparam rate_div_t DEFAULT_RATE_DIV   = 16'd6944;   // 7200 Hz
  localparam rate_div_t DEFAULT_RATE_STEP  = 16'd100;
  localparam int        DEFAULT_KEY_REPEAT = 5_000_000;  // 10 changes per second

  // Samples in the level average
  localparam int LEVEL_WINDOW = 8;

endpackage

`default_nettype wire

// ==== rate/sample_rate_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module sample_rate_gen
  import audio_pkg::*;
#(
  parameter rate_div_t RATE_DIV_RESET = DEFAULT_RATE_DIV,
  parameter rate_div_t RATE_STEP      = DEFAULT_RATE_STEP,
  parameter int        KEY_REPEAT     = DEFAULT_KEY_REPEAT
)
(
  input  logic      CLK_50M,
  input  logic      arst_n,
  input  logic      key_up,
  input  logic      key_down,
  input  logic      key_reset,
  output logic      tick,
  output rate_div_t rate_div
);

  localparam int RPT_W = $clog2(KEY_REPEAT + 1);

  logic [RPT_W-1:0] repeat_cnt;
  logic             repeat_open;
  logic             key_accept;
  logic [16:0]      div_sum;
  rate_div_t        div_faster;
  rate_div_t        div_slower;
  rate_div_t        tick_cnt;

  assign repeat_open = (repeat_cnt == '0);
  assign key_accept  = repeat_open && (key_up || key_down) && !key_reset;

  // Clamped step results
  assign div_sum    = {1'b0, rate_div} + {1'b0, RATE_STEP};
  assign div_slower = div_sum[16] ? 16'hFFFF : div_sum[15:0];
  assign div_faster = ({1'b0, rate_div} < {RATE_STEP, 1'b0}) ? RATE_STEP
                                                             : rate_div - RATE_STEP;

  // ============================================================
  // Key handling
  // ============================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      repeat_cnt <= RPT_W'(KEY_REPEAT);  // Blocked until first expiry
      rate_div   <= RATE_DIV_RESET;
    end
    else
    begin
      if (key_reset)
        rate_div <= RATE_DIV_RESET;
      else if (key_accept)
        rate_div <= key_up ? div_faster : div_slower;  // Up wins over down

      if (key_accept)
        repeat_cnt <= RPT_W'(KEY_REPEAT);
      else if (!repeat_open)
        repeat_cnt <= repeat_cnt - 1'b1;
    end
  end

  // Tick every rate_div cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end
    else if (tick_cnt >= rate_div - 1'b1)  // Also catches a shrinking divider
    begin
      tick_cnt <= '0;
      tick     <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
      tick     <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== playback/phoneme_table.sv ====
`default_nettype none
`timescale 1ns/1ps

module phoneme_table
  import flash_pkg::*;
(
  input  logic           CLK_50M,
  input  logic           arst_n,
  input  logic           start,
  input  phoneme_t       phoneme,
  output phoneme_range_t range,
  output logic           range_valid
);

  flash_addr_t base;

  assign base = phoneme_base(phoneme);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      range_valid <= 1'b0;
    else
      range_valid <= start;  // One cycle behind start
  end

  // Lookup captured on start
  always_ff @(posedge CLK_50M)
  begin
    if (start)
    begin
      range.start_addr <= base;
      range.end_addr   <= base + flash_addr_t'(PHONEME_WORDS - 1);
      range.silent     <= (phoneme == PH_SIL);
    end
  end

endmodule

`default_nettype wire

// ==== playback/flash_reader.sv ====
`default_nettype none
`timescale 1ns/1ps

module flash_reader
  import flash_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic        fetch,
  input  flash_addr_t fetch_addr,
  output flash_req_t  flash_req,
  input  flash_rsp_t  flash_rsp,
  output flash_word_t word,
  output logic        word_valid
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT} rd_state_t;

  rd_state_t   state;
  flash_addr_t addr_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (fetch)
            state <= ISSUE;
        end
        ISSUE:
          state <= WAIT;
        WAIT:
        begin
          if (flash_rsp.readdatavalid)  // No new read before this
          begin
            word_valid <= 1'b1;
            state      <= IDLE;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && fetch)
      addr_q <= fetch_addr;
    if (state == WAIT && flash_rsp.readdatavalid)
      word <= flash_rsp.data;
  end

  assign flash_req.read = (state == ISSUE);  // Single-cycle read
  assign flash_req.addr = addr_q;

endmodule

`default_nettype wire

// ==== playback/phrase_player.sv ====
`default_nettype none
`timescale 1ns/1ps

module phrase_player
  import flash_pkg::*, audio_pkg::*;
(
  input  logic           CLK_50M,
  input  logic           arst_n,
  input  logic           start,
  input  phoneme_range_t range,
  input  logic           range_valid,
  input  logic           tick,
  output logic           fetch,
  output flash_addr_t    fetch_addr,
  input  flash_word_t    word,
  input  logic           word_valid,
  output sample_t        sample,
  output logic           sample_valid,
  output logic           busy,
  output logic           done
);

  typedef enum logic [1:0] {IDLE, LOAD, PLAY, FINISH} play_state_t;

  play_state_t state;
  logic        silent;
  flash_addr_t end_addr;
  flash_addr_t play_addr;    // Word now playing
  logic        fetch_done;
  logic        pending;      // Read in flight
  flash_word_t cur_word;
  flash_word_t next_word;
  logic        cur_full;
  logic        next_full;
  logic        load_cur;
  logic [1:0]  byte_idx;

  assign load_cur     = (state == PLAY) && !cur_full && next_full;
  assign sample_valid = (state == PLAY) && tick && (silent || cur_full);
  assign sample       = silent ? '0 : sample_t'(cur_word[{byte_idx, 3'b000} +: 8]);
  assign fetch        = (state == PLAY) && !silent && !fetch_done && !pending && !next_full;
  assign busy         = (state == LOAD) || (state == PLAY);
  assign done         = (state == FINISH);

  // ============================================================
  // Phrase FSM
  // ============================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= IDLE;
      silent     <= 1'b0;
      end_addr   <= '0;
      play_addr  <= '0;
      fetch_addr <= '0;
      fetch_done <= 1'b0;
      pending    <= 1'b0;
      cur_full   <= 1'b0;
      next_full  <= 1'b0;
      byte_idx   <= 2'd0;
    end
    else
    begin
      case (state)
        IDLE, FINISH:
          state <= start ? LOAD : IDLE;
        LOAD:
        begin
          if (range_valid)
          begin
            state      <= PLAY;
            silent     <= range.silent;
            end_addr   <= range.end_addr;
            play_addr  <= range.start_addr;
            fetch_addr <= range.start_addr;
            fetch_done <= 1'b0;
            pending    <= 1'b0;
            cur_full   <= 1'b0;
            next_full  <= 1'b0;
            byte_idx   <= 2'd0;
          end
        end
        PLAY:
        begin
          if (fetch)
          begin
            pending    <= 1'b1;
            fetch_addr <= fetch_addr + 1'b1;
            if (fetch_addr == end_addr)
              fetch_done <= 1'b1;
          end
          if (word_valid)
          begin
            pending   <= 1'b0;
            next_full <= 1'b1;
          end
          if (load_cur)
          begin
            cur_full  <= 1'b1;
            next_full <= 1'b0;
          end
          if (sample_valid)
          begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3)  // Word used up
            begin
              cur_full  <= 1'b0;
              play_addr <= play_addr + 1'b1;
              if (play_addr == end_addr)
                state <= FINISH;
            end
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Prefetch buffer and current word
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
      next_word <= word;
    if (load_cur)
      cur_word <= next_word;
  end

endmodule

`default_nettype wire

// ==== logic/level_meter.sv ====
`default_nettype none
`timescale 1ns/1ps

module level_meter
  import audio_pkg::*;
(
  input  logic     CLK_50M,
  input  logic     arst_n,
  input  sample_t  sample,
  input  logic     sample_valid,
  output led_bar_t leds
);

  localparam int AVG_SHIFT = $clog2(LEVEL_WINDOW);
  localparam int SUM_W     = 7 + AVG_SHIFT;

  logic [6:0]       mag_hist [LEVEL_WINDOW];
  logic [SUM_W-1:0] mag_sum;
  logic [7:0]       neg;
  logic [6:0]       mag;
  logic [2:0]       lit;

  assign neg = -sample;

  always_comb
  begin
    if (!sample[7])
      mag = sample[6:0];
    else if (neg[7])
      mag = 7'd127;  // -128 saturates
    else
      mag = neg[6:0];
  end

  // Running sum over the window
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mag_sum <= '0;
      for (int i = 0; i < LEVEL_WINDOW; i++)
        mag_hist[i] <= '0;
    end
    else if (sample_valid)
    begin
      mag_sum     <= mag_sum + SUM_W'(mag) - SUM_W'(mag_hist[LEVEL_WINDOW-1]);
      mag_hist[0] <= mag;
      for (int i = 1; i < LEVEL_WINDOW; i++)
        mag_hist[i] <= mag_hist[i-1];
    end
  end

  // Average / 16 sets bar length
  assign lit  = 3'(mag_sum >> (AVG_SHIFT + 4));
  assign leds = led_bar_t'((9'd1 << lit) - 9'd1);

endmodule

`default_nettype wire

// ==== logic/speech_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module speech_top
  import flash_pkg::*, audio_pkg::*;
#(
  parameter rate_div_t RATE_DIV_RESET = DEFAULT_RATE_DIV,
  parameter rate_div_t RATE_STEP      = DEFAULT_RATE_STEP,
  parameter int        KEY_REPEAT     = DEFAULT_KEY_REPEAT
)
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic       start,
  input  phoneme_t   phoneme,
  input  logic       key_up,
  input  logic       key_down,
  input  logic       key_reset,
  output flash_req_t flash_req,
  input  flash_rsp_t flash_rsp,
  output sample_t    sample,
  output logic       sample_valid,
  output logic       busy,
  output logic       done,
  output led_bar_t   leds,
  output rate_div_t  rate_div
);

  logic           tick;
  phoneme_range_t range;
  logic           range_valid;
  logic           fetch;
  flash_addr_t    fetch_addr;
  flash_word_t    word;
  logic           word_valid;

  // ============================================================
  // Rate and playback
  // ============================================================

  sample_rate_gen #(
    .RATE_DIV_RESET (RATE_DIV_RESET),
    .RATE_STEP      (RATE_STEP),
    .KEY_REPEAT     (KEY_REPEAT)
  ) u_rate (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_up    (key_up),
    .key_down  (key_down),
    .key_reset (key_reset),
    .tick      (tick),
    .rate_div  (rate_div)
  );

  phoneme_table u_table (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .start       (start),
    .phoneme     (phoneme),
    .range       (range),
    .range_valid (range_valid)
  );

  flash_reader u_reader (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .flash_req  (flash_req),
    .flash_rsp  (flash_rsp),
    .word       (word),
    .word_valid (word_valid)
  );

  phrase_player u_player (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .start        (start),
    .range        (range),
    .range_valid  (range_valid),
    .tick         (tick),
    .fetch        (fetch),
    .fetch_addr   (fetch_addr),
    .word         (word),
    .word_valid   (word_valid),
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .done         (done)
  );

  level_meter u_meter (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .leds         (leds)
  );

endmodule

`default_nettype wire

// ==== verif/flash_model.sv ====
`default_nettype none
`timescale 1ns/1ps

module flash_model
  import flash_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  flash_req_t flash_req,
  output flash_rsp_t flash_rsp
);

  int          seed = 65;
  int          lat;
  int          wait_cnt;
  logic        in_flight;
  flash_addr_t addr_q;

  // Word contents depend on every address bit
  function automatic flash_word_t word_at(input flash_addr_t addr);
    return ({9'd0, addr} * 32'h0101_0101) ^ 32'hA5C3_5A3C;
  endfunction

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      in_flight <= 1'b0;
      wait_cnt  <= 0;
      addr_q    <= '0;
      flash_rsp <= '0;
    end
    else
    begin
      flash_rsp.readdatavalid <= 1'b0;
      if (flash_req.read)
      begin
        lat = 1 + ($random(seed) & 3);  // 1 to 4 cycles
        if (lat == 1)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.data          <= word_at(flash_req.addr);
        end
        else
        begin
          addr_q    <= flash_req.addr;
          in_flight <= 1'b1;
          wait_cnt  <= lat - 1;
        end
      end
      else if (in_flight)
      begin
        if (wait_cnt == 1)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.data          <= word_at(addr_q);
          in_flight               <= 1'b0;
        end
        else
          wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_speech_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_speech_top
  import flash_pkg::*, audio_pkg::*;
();

  localparam rate_div_t TB_RATE_DIV = 16'd20;
  localparam rate_div_t TB_STEP     = 16'd4;
  localparam int        TB_REPEAT   = 6;
  localparam int        WAIT_LIMIT  = 5000;  // Cycles per wait loop

  logic       CLK_50M;
  logic       arst_n;
  logic       start;
  phoneme_t   phoneme;
  logic       key_up;
  logic       key_down;
  logic       key_reset;
  flash_req_t flash_req;
  flash_rsp_t flash_rsp;
  sample_t    sample;
  logic       sample_valid;
  logic       busy;
  logic       done;
  led_bar_t   leds;
  rate_div_t  rate_div;

  // Bookkeeping
  int       cyc = 0;
  int       err_cnt = 0;
  int       tests_run = 0;
  int       tests_failed = 0;
  int       model_div;
  int       last_accept;
  sample_t  got_q[$];
  led_bar_t led_got_q[$];
  led_bar_t led_exp_q[$];
  int       done_cnt = 0;
  int       read_cnt = 0;
  int       done_gap = 0;
  logic     busy_at_done = 1'b0;
  int       last_sample_cyc = 0;
  int       hist [8] = '{default: 0};
  int       mag_sum = 0;
  led_bar_t led_exp = '0;
  logic     led_due = 1'b0;

  speech_top #(
    .RATE_DIV_RESET (TB_RATE_DIV),
    .RATE_STEP      (TB_STEP),
    .KEY_REPEAT     (TB_REPEAT)
  ) dut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .start        (start),
    .phoneme      (phoneme),
    .key_up       (key_up),
    .key_down     (key_down),
    .key_reset    (key_reset),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .done         (done),
    .leds         (leds),
    .rate_div     (rate_div)
  );

  flash_model u_flash (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
    cyc <= cyc + 1;

  // ============================================================
  // Reference functions
  // ============================================================

  function automatic logic [31:0] flash_word(input int addr);
    return (addr * 32'h0101_0101) ^ 32'hA5C3_5A3C;
  endfunction

  function automatic int magnitude(input sample_t s);
    if (s == sample_t'(8'h80))
      return 127;  // Full scale negative saturates
    else if (s < 0)
      return -int'(s);
    else
      return int'(s);
  endfunction

  function automatic led_bar_t thermometer(input int sum);
    int lit;
    lit = (sum / 8) / 16;
    return led_bar_t'((1 << lit) - 1);
  endfunction

  // ============================================================
  // Checks and reporting
  // ============================================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    err_cnt = err_cnt + 1;
  endtask

  task automatic finish_test(input string desc, input int err_before);
    tests_run = tests_run + 1;
    if (err_cnt != err_before)
    begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d error(s)", tests_run, desc, err_cnt - err_before);
    end
    else
      $display("test %0d %s: ok", tests_run, desc);
  endtask

  // Output monitor, sampled mid-cycle
  always @(negedge CLK_50M)
  begin
    if (led_due)
    begin
      led_got_q.push_back(leds);
      led_exp_q.push_back(led_exp);
      led_due = 1'b0;
    end
    if (sample_valid)
    begin
      got_q.push_back(sample);
      last_sample_cyc = cyc;
      mag_sum = mag_sum + magnitude(sample) - hist[7];
      for (int i = 7; i > 0; i--)
        hist[i] = hist[i-1];
      hist[0] = magnitude(sample);
      led_exp = thermometer(mag_sum);
      led_due = 1'b1;
    end
    if (done)
    begin
      done_cnt     = done_cnt + 1;
      done_gap     = cyc - last_sample_cyc;
      busy_at_done = busy;
    end
    if (flash_req.read)
      read_cnt = read_cnt + 1;
  end

  // ============================================================
  // Stimulus tasks
  // ============================================================

  task automatic play_phoneme(input int code);
    sample_t     exp_q[$];
    logic [31:0] w;
    int          done_base;
    int          read_base;
    int          sample_base;
    int          led_base;
    int          waited;
    if (code == 7)
    begin
      for (int i = 0; i < 16; i++)
        exp_q.push_back(sample_t'(8'h00));
    end
    else
    begin
      for (int a = code * 8; a <= code * 8 + 3; a++)
      begin
        w = flash_word(a);
        for (int b = 0; b < 4; b++)
          exp_q.push_back(sample_t'(w[8*b +: 8]));  // Lowest byte first
      end
    end

    @(posedge CLK_50M);
    done_base   = done_cnt;
    read_base   = read_cnt;
    sample_base = got_q.size();
    led_base    = led_got_q.size();

    @(negedge CLK_50M);
    phoneme = phoneme_t'(code);
    start   = 1'b1;
    @(negedge CLK_50M);
    start = 1'b0;
    check_value("busy", {31'd0, busy}, 32'd1);
    repeat (2) @(negedge CLK_50M);
    phoneme = phoneme_t'((code + 1) % 8);  // Start while busy
    start   = 1'b1;
    @(negedge CLK_50M);
    start = 1'b0;

    waited = 0;
    while (done_cnt == done_base && waited < WAIT_LIMIT)
    begin
      @(posedge CLK_50M);
      waited = waited + 1;
    end
    if (done_cnt == done_base)
      report_failure("timeout: done never came after start of the phrase");
    repeat (3 * int'(rate_div)) @(posedge CLK_50M);  // Quiet window after done
    @(negedge CLK_50M);

    check_value("done_count", 32'(done_cnt - done_base), 32'd1);
    check_value("done_gap", 32'(done_gap), 32'd1);
    check_value("busy_at_done", {31'd0, busy_at_done}, 32'd0);
    check_value("read_count", 32'(read_cnt - read_base), (code == 7) ? 32'd0 : 32'd4);
    check_value("sample_count", 32'(got_q.size() - sample_base), 32'd16);
    for (int i = 0; i < 16 && sample_base + i < got_q.size(); i++)
      check_value($sformatf("sample[%0d]", i), {24'd0, got_q[sample_base + i]},
                  {24'd0, exp_q[i]});
    check_value("led_count", 32'(led_got_q.size() - led_base), 32'd16);
    for (int i = led_base; i < led_got_q.size(); i++)
      check_value("leds", {24'd0, led_got_q[i]}, {24'd0, led_exp_q[i]});
    if (code == 7)
      check_value("leds_final", {24'd0, leds}, 32'd0);
  endtask

  task automatic press_key(input logic [63:0] key_name, input int exp_div);
    int   press_edge;
    logic is_up;
    @(negedge CLK_50M);
    press_edge = cyc + 1;
    is_up      = (key_name == 64'("up"));
    if (key_name == 64'("reset"))
    begin
      key_reset = 1'b1;
      model_div = int'(TB_RATE_DIV);  // Reset ignores the repeat window
    end
    else if (is_up || key_name == 64'("down"))
    begin
      key_up   = is_up;
      key_down = !is_up;
      if (press_edge - last_accept > TB_REPEAT)
      begin
        last_accept = press_edge;
        if (is_up)
          model_div = (model_div - int'(TB_STEP) < int'(TB_STEP)) ? int'(TB_STEP)
                                                                  : model_div - int'(TB_STEP);
        else
          model_div = (model_div + int'(TB_STEP) > 65535) ? 65535
                                                          : model_div + int'(TB_STEP);
      end
    end
    else
      report_failure("unknown key name in the stimulus file");
    @(negedge CLK_50M);
    key_up    = 1'b0;
    key_down  = 1'b0;
    key_reset = 1'b0;
    check_value("rate_div", {16'd0, rate_div}, 32'(model_div));
    check_value("rate_div_stim", {16'd0, rate_div}, 32'(exp_div));
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial
  begin
    logic [8*80-1:0] line;
    logic [63:0]     cmd;
    logic [63:0]     arg;
    int              num;
    int              n;
    int              fd;
    int              err_before;

    arst_n    = 1'b0;
    start     = 1'b0;
    phoneme   = PH_AA;
    key_up    = 1'b0;
    key_down  = 1'b0;
    key_reset = 1'b0;
    repeat (4) @(negedge CLK_50M);
    arst_n      = 1'b1;
    last_accept = cyc;  // Repeat counter starts blocked
    model_div   = int'(TB_RATE_DIV);

    err_before = err_cnt;
    @(negedge CLK_50M);
    check_value("rate_div", {16'd0, rate_div}, {16'd0, TB_RATE_DIV});
    check_value("leds", {24'd0, leds}, 32'd0);
    check_value("busy", {31'd0, busy}, 32'd0);
    check_value("done", {31'd0, done}, 32'd0);
    check_value("sample_valid", {31'd0, sample_valid}, 32'd0);
    check_value("flash_read", {31'd0, flash_req.read}, 32'd0);
    finish_test("reset values", err_before);

    fd = $fopen("verif/speech_stim.txt", "r");
    if (fd == 0)
      report_failure("cannot open the stimulus file verif/speech_stim.txt");
    else
    begin
      line = '0;
      while ($fgets(line, fd) != 0)
      begin
        cmd = '0;
        arg = '0;
        n   = $sscanf(line, "%s", cmd);
        if (n == 1 && cmd != 64'("#"))
        begin
          err_before = err_cnt;
          if (cmd == 64'("P"))
          begin
            n = $sscanf(line, "%s %d", cmd, num);
            if (n != 2 || num < 0 || num > 7)
              report_failure("malformed play line in the stimulus file");
            else
              play_phoneme(num);
            finish_test($sformatf("play phoneme %0d", num), err_before);
          end
          else if (cmd == 64'("K"))
          begin
            n = $sscanf(line, "%s %s %d", cmd, arg, num);
            if (n != 3)
              report_failure("malformed key line in the stimulus file");
            else
              press_key(arg, num);
            finish_test($sformatf("key %0s to %0d", arg, num), err_before);
          end
          else
            report_failure("unknown command in the stimulus file");
        end
        line = '0;
      end
      $fclose(fd);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/speech_stim.txt ====
# P <phoneme code 0..7, 7 is silent> : play one phrase
# K <up|down|reset> <expected rate_div> : press one key for one cycle
P 0
K up 16
K up 16
P 1
K up 12
K down 12
P 2
K up 8
P 7
K up 4
P 3
K up 4
K reset 20
P 4
K down 24
P 5
P 6

// ==== speech_player.f ====
common/flash_pkg.sv
common/audio_pkg.sv
rate/sample_rate_gen.sv
playback/phoneme_table.sv
playback/flash_reader.sv
playback/phrase_player.sv
logic/level_meter.sv
logic/speech_top.sv
verif/flash_model.sv
verif/tb_speech_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_speech_top
FILELIST  = speech_player.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
